// File: logic/board_color_pkg.sv
package board_color_pkg;

    // Cells on one 5 by 5 board
    localparam int CELL_COUNT = 25;

    typedef logic [3:0] cell_code_t;

    // Element k is the cell at screen row r and column c, with k = (4 - r) * 5 + (4 - c)
    // so element 24 is the top left cell and element 0 the bottom right one
    typedef cell_code_t [CELL_COUNT-1:0] board_cells_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_rgb_t;

    // Cell codes that select a colour of their own
    localparam cell_code_t CODE_WATER      = 4'd0;
    localparam cell_code_t CODE_SHIP_FIRST = 4'd1;
    localparam cell_code_t CODE_SHIP_LAST  = 4'd5;
    localparam cell_code_t CODE_YELLOW     = 4'd6;
    localparam cell_code_t CODE_ORANGE     = 4'd7;
    localparam cell_code_t CODE_RED        = 4'd8;
    localparam cell_code_t CODE_GREEN      = 4'd9;

    // Palette
    localparam pixel_rgb_t COLOR_BLACK  = '{r: 8'h00, g: 8'h00, b: 8'h00};
    localparam pixel_rgb_t COLOR_WHITE  = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};
    localparam pixel_rgb_t COLOR_WATER  = '{r: 8'h00, g: 8'h00, b: 8'hFF};
    localparam pixel_rgb_t COLOR_SHIP   = '{r: 8'h80, g: 8'h80, b: 8'h80};
    localparam pixel_rgb_t COLOR_YELLOW = '{r: 8'hFF, g: 8'hFF, b: 8'h00};
    localparam pixel_rgb_t COLOR_ORANGE = '{r: 8'hFF, g: 8'h7F, b: 8'h00};
    localparam pixel_rgb_t COLOR_RED    = '{r: 8'hFF, g: 8'h00, b: 8'h00};
    localparam pixel_rgb_t COLOR_GREEN  = '{r: 8'h00, g: 8'hFF, b: 8'h00};

endpackage

// File: logic/board_geometry_pkg.sv
package board_geometry_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [2:0] cell_idx_t;

    // Vertical extent shared by both boards with the lines included
    localparam coord_t GRID_TOP    = 10'd100;
    localparam coord_t GRID_BOTTOM = 10'd450;

    // Line pitch in x and in y
    localparam int CELL_W = 54;
    localparam int CELL_H = 70;

    localparam int GRID_N     = 5;
    localparam int BOARD_SPAN = 270;
    localparam int NUM_BOARDS = 2;

    // Board 0 is the computer and board 1 the player
    localparam coord_t [NUM_BOARDS-1:0] BOARD_ORIGIN_X = {10'd345, 10'd25};

    // Result of the y decode carried with the registered x
    typedef struct packed {
        coord_t    x;
        logic      in_span;
        logic      on_hline;
        logic      in_row;
        cell_idx_t row;
    } row_info_t;

    // What one board contributes to a pixel
    typedef struct packed {
        logic                      on_line;
        logic                      in_cell;
        board_color_pkg::cell_code_t code;
    } board_hit_t;

endpackage

// File: logic/row_decoder.sv
`timescale 1ns/100ps

module row_decoder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  board_geometry_pkg::coord_t    x,
    input  board_geometry_pkg::coord_t    y,
    output board_geometry_pkg::row_info_t row_q
);

    import board_geometry_pkg::*;

    logic              hline_hit;
    logic [GRID_N-1:0] band_hit;
    cell_idx_t         row_d;
    logic              span_d;

    always_comb begin
        hline_hit = 1'b0;
        band_hit  = '0;
        row_d     = '0;
        // Six horizontal lines bound five bands
        for (int k = 0; k <= GRID_N; k++) begin
            if (y == coord_t'(GRID_TOP + k * CELL_H)) begin
                hline_hit = 1'b1;
            end
        end
        for (int k = 0; k < GRID_N; k++) begin
            if (y > coord_t'(GRID_TOP + k * CELL_H) &&
                y < coord_t'(GRID_TOP + (k + 1) * CELL_H)) begin
                band_hit[k] = 1'b1;
                row_d       = cell_idx_t'(k);
            end
        end
    end

    assign span_d = (y >= GRID_TOP) && (y <= GRID_BOTTOM);

    // Stage 1 is shared by both boards
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q <= '0;
        end else begin
            row_q.x        <= x;
            row_q.in_span  <= span_d;
            row_q.on_hline <= hline_hit;
            row_q.in_row   <= |band_hit;
            row_q.row      <= row_d;
        end
    end

endmodule

// File: logic/board_painter.sv
`timescale 1ns/100ps

module board_painter #(
    parameter board_geometry_pkg::coord_t ORIGIN_X = 10'd25
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  board_geometry_pkg::row_info_t  row_q,
    input  board_color_pkg::board_cells_t  cells,
    output board_geometry_pkg::board_hit_t hit
);

    import board_geometry_pkg::*;
    import board_color_pkg::*;

    logic              vline_hit;
    logic [GRID_N-1:0] col_hit;
    cell_idx_t         col;
    logic              in_hspan;
    logic              on_line_d;
    logic              in_cell_d;
    logic [4:0]        cell_sel;
    cell_code_t        code_d;

    always_comb begin
        vline_hit = 1'b0;
        col_hit   = '0;
        col       = '0;
        for (int k = 0; k <= GRID_N; k++) begin
            if (row_q.x == coord_t'(ORIGIN_X + k * CELL_W)) begin
                vline_hit = 1'b1;
            end
        end
        // Column interiors sit one pixel in from each bounding line
        for (int c = 0; c < GRID_N; c++) begin
            if (row_q.x >= coord_t'(ORIGIN_X + 1 + c * CELL_W) &&
                row_q.x <= coord_t'(ORIGIN_X + CELL_W - 1 + c * CELL_W)) begin
                col_hit[c] = 1'b1;
                col        = cell_idx_t'(c);
            end
        end
    end

    assign in_hspan = (row_q.x >= ORIGIN_X) &&
                      (row_q.x <= coord_t'(ORIGIN_X + BOARD_SPAN));

    // Vertical lines run the full y span, horizontal lines the full board width
    assign on_line_d = (vline_hit && row_q.in_span) || (row_q.on_hline && in_hspan);
    assign in_cell_d = row_q.in_row && (|col_hit);

    // Cells are stored bottom right first
    assign cell_sel = 5'((GRID_N - 1 - int'(row_q.row)) * GRID_N +
                         (GRID_N - 1 - int'(col)));

    assign code_d = in_cell_d ? cells[cell_sel] : CODE_WATER;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= '0;
        end else begin
            hit.on_line <= on_line_d;
            hit.in_cell <= in_cell_d;
            hit.code    <= code_d;
        end
    end

endmodule

// File: logic/board_compositor.sv
`timescale 1ns/100ps

module board_compositor (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  board_geometry_pkg::board_hit_t [board_geometry_pkg::NUM_BOARDS-1:0] hits,
    output board_color_pkg::pixel_rgb_t                                rgb
);

    import board_geometry_pkg::*;
    import board_color_pkg::*;

    logic       any_line;
    logic       any_cell;
    cell_code_t cell_code;
    pixel_rgb_t rgb_d;

    function automatic pixel_rgb_t palette(input cell_code_t code);
        pixel_rgb_t color;
        if (code == CODE_WATER) begin
            color = COLOR_WATER;
        end else if (code >= CODE_SHIP_FIRST && code <= CODE_SHIP_LAST) begin
            color = COLOR_SHIP;
        end else if (code == CODE_YELLOW) begin
            color = COLOR_YELLOW;
        end else if (code == CODE_ORANGE) begin
            color = COLOR_ORANGE;
        end else if (code == CODE_RED) begin
            color = COLOR_RED;
        end else if (code == CODE_GREEN) begin
            color = COLOR_GREEN;
        end else begin
            color = COLOR_BLACK;
        end
        return color;
    endfunction

    always_comb begin
        any_line  = 1'b0;
        any_cell  = 1'b0;
        cell_code = CODE_WATER;
        // The boards never overlap, so at most one reports a cell
        for (int i = 0; i < NUM_BOARDS; i++) begin
            any_line = any_line | hits[i].on_line;
            if (hits[i].in_cell) begin
                any_cell  = 1'b1;
                cell_code = hits[i].code;
            end
        end
    end

    // Lines win over cells
    assign rgb_d = any_line ? COLOR_WHITE :
                   any_cell ? palette(cell_code) : COLOR_BLACK;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= COLOR_BLACK;
        end else begin
            rgb <= rgb_d;
        end
    end

endmodule

// File: logic/battleship_video.sv
`timescale 1ns/100ps

module battleship_video (
    input  logic                          clk,
    input  logic                          rst_n,
    input  board_geometry_pkg::coord_t    x,
    input  board_geometry_pkg::coord_t    y,
    input  board_color_pkg::board_cells_t pc_cells,
    input  board_color_pkg::board_cells_t player_cells,
    output board_color_pkg::pixel_rgb_t   rgb
);

    import board_geometry_pkg::*;
    import board_color_pkg::*;

    row_info_t                     row_q;
    board_hit_t   [NUM_BOARDS-1:0] hits;
    board_cells_t [NUM_BOARDS-1:0] board_cells;

    // Board 0 is the computer, board 1 the player
    assign board_cells = {player_cells, pc_cells};

    row_decoder u_row_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (x),
        .y     (y),
        .row_q (row_q)
    );

    // Each board gets a painter with its own left edge
    for (genvar i = 0; i < NUM_BOARDS; i++) begin : g_board
        board_painter #(
            .ORIGIN_X (BOARD_ORIGIN_X[i])
        ) u_painter (
            .clk   (clk),
            .rst_n (rst_n),
            .row_q (row_q),
            .cells (board_cells[i]),
            .hit   (hits[i])
        );
    end

    board_compositor u_compositor (
        .clk   (clk),
        .rst_n (rst_n),
        .hits  (hits),
        .rgb   (rgb)
    );

endmodule

// File: verif/battleship_video_model.svh
`ifndef BATTLESHIP_VIDEO_MODEL_SVH
`define BATTLESHIP_VIDEO_MODEL_SVH

// Colour of a cell interior for one cell code
function automatic logic [23:0] code_color(input logic [3:0] code);
    case (code)
        4'd0: return 24'h0000FF;
        4'd1, 4'd2, 4'd3, 4'd4, 4'd5: return 24'h808080;
        4'd6: return 24'hFFFF00;
        4'd7: return 24'hFF7F00;
        4'd8: return 24'hFF0000;
        4'd9: return 24'h00FF00;
        default: return 24'h000000;
    endcase
endfunction

// Expected colour of the pixel at px, py for the two boards given
function automatic logic [23:0] expected_pixel(input int px, input int py,
                                               input logic [99:0] pc,
                                               input logic [99:0] player);
    int          left;
    int          dx;
    int          dy;
    int          k;
    logic [99:0] cells;
    logic [23:0] color;
    color = 24'h000000;
    dy    = py - 100;
    for (int b = 0; b < 2; b++) begin
        left  = (b == 0) ? 25 : 345;
        cells = (b == 0) ? pc : player;
        dx    = px - left;
        if (dx >= 0 && dx <= 270 && dy >= 0 && dy <= 350) begin
            // Every multiple of the pitch inside the box is a white line
            if (dx % 54 == 0 || dy % 70 == 0) begin
                return 24'hFFFFFF;
            end
            // Cells are stored from the bottom right corner upwards
            k     = (4 - dy / 70) * 5 + (4 - dx / 54);
            color = code_color(cells[4 * k +: 4]);
        end
    end
    return color;
endfunction

`endif

// File: verif/battleship_video_tb.sv
`timescale 1ns/100ps

module battleship_video_tb;

    import board_geometry_pkg::*;
    import board_color_pkg::*;

    `include "battleship_video_model.svh"

    localparam int BOARD_LEFT [2] = '{25, 345};

    // Pixels driven by each test set the watchdog time
    localparam int GRID_PIXELS    = 2 * 6 * (351 + 271);
    localparam int PALETTE_PIXELS = 16 * 250;
    localparam int ORDER_PIXELS   = 50 * 250;
    localparam int OUTSIDE_PIXELS = 2 * 500;
    localparam int PIPE_PIXELS    = 2000;
    localparam int WATCHDOG_NS    = 10 * (GRID_PIXELS + PALETTE_PIXELS + ORDER_PIXELS +
                                          OUTSIDE_PIXELS + PIPE_PIXELS + 500);

    logic                  clk = 1'b0;
    logic                  rst_n;
    coord_t                x;
    coord_t                y;
    board_cells_t          pc_cells;
    board_cells_t          player_cells;
    pixel_rgb_t            rgb;
    coord_t       [2:0]    x_d;
    coord_t       [2:0]    y_d;
    board_cells_t [1:0]    pc_d;
    board_cells_t [1:0]    player_d;
    logic         [23:0]   expected;
    int                    settled = 0;
    int                    errors = 0;
    int                    checks = 0;

    battleship_video dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .x            (x),
        .y            (y),
        .pc_cells     (pc_cells),
        .player_cells (player_cells),
        .rgb          (rgb)
    );

    always #5 clk = ~clk;

    // x and y enter stage 1 and the cells are taken one edge later
    always @(posedge clk) begin
        x_d      <= {x_d[1:0], x};
        y_d      <= {y_d[1:0], y};
        pc_d     <= {pc_d[0], pc_cells};
        player_d <= {player_d[0], player_cells};
        checks   <= checks + 1;
        if (!rst_n) begin
            settled <= 0;
        end else if (settled < 3) begin
            settled <= settled + 1;
        end
    end

    assign expected = expected_pixel(int'(x_d[2]), int'(y_d[2]), pc_d[1], player_d[1]);

    reset_black: assert property (@(posedge clk) settled < 3 |-> rgb == 24'h000000)
        else begin
            errors++;
            $display("Error: rgb at %0d ns, expected 000000, got %06h", $time, $sampled(rgb));
        end

    pixel_color: assert property (@(posedge clk) settled >= 3 |-> rgb == expected)
        else begin
            errors++;
            $display("Error: rgb at %0d ns, expected %06h, got %06h",
                     $time, $sampled(expected), $sampled(rgb));
        end

    task automatic drive_pixel(input int px, input int py);
        @(posedge clk);
        x <= coord_t'(px);
        y <= coord_t'(py);
    endtask

    // Four interior corners and the centre of every cell on both boards
    task automatic drive_cell_interiors();
        int left;
        int top;
        for (int b = 0; b < 2; b++) begin
            for (int r = 0; r < 5; r++) begin
                for (int c = 0; c < 5; c++) begin
                    left = BOARD_LEFT[b] + 54 * c;
                    top  = 100 + 70 * r;
                    drive_pixel(left + 1, top + 1);
                    drive_pixel(left + 53, top + 1);
                    drive_pixel(left + 1, top + 69);
                    drive_pixel(left + 53, top + 69);
                    drive_pixel(left + 27, top + 35);
                end
            end
        end
    endtask

    // Drains the pipeline so every check of the test has been made
    task automatic finish_test(input string name, input int errors_before);
        repeat (5) drive_pixel(0, 0);
        $display("%s: %0d errors", name, errors - errors_before);
    endtask

    function automatic board_cells_t random_cells();
        board_cells_t cells;
        for (int k = 0; k < 25; k++) begin
            cells[k] = cell_code_t'($urandom_range(15, 0));
        end
        return cells;
    endfunction

    initial begin
        int           base;
        int           px;
        int           py;
        board_cells_t cells;
        void'($urandom(32'h02e3_72ce));
        rst_n        <= 1'b0;
        x            <= '0;
        y            <= '0;
        pc_cells     <= '0;
        player_cells <= '0;

        base = errors;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        finish_test("reset", base);

        base = errors;
        pc_cells     <= random_cells();
        player_cells <= random_cells();
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k <= 5; k++) begin
                for (int v = 100; v <= 450; v++) begin
                    drive_pixel(BOARD_LEFT[b] + 54 * k, v);
                end
                for (int u = 0; u <= 270; u++) begin
                    drive_pixel(BOARD_LEFT[b] + u, 100 + 70 * k);
                end
            end
        end
        finish_test("grid lines", base);

        base = errors;
        for (int s = 0; s < 16; s++) begin
            for (int k = 0; k < 25; k++) begin
                cells[k] = cell_code_t'((k + s) % 16);
            end
            pc_cells     <= cells;
            player_cells <= ~cells;
            drive_cell_interiors();
        end
        finish_test("palette", base);

        base = errors;
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k < 25; k++) begin
                cells    = '0;
                cells[k] = cell_code_t'(6 + k % 4);
                pc_cells     <= (b == 0) ? cells : '0;
                player_cells <= (b == 1) ? cells : '0;
                drive_cell_interiors();
            end
        end
        finish_test("cell order", base);

        base = errors;
        pc_cells     <= random_cells();
        player_cells <= random_cells();
        for (int i = 0; i < 500; i++) begin
            do begin
                px = $urandom_range(1023, 0);
                py = $urandom_range(1023, 0);
            end while (py >= 100 && py <= 450 &&
                       ((px >= 25 && px <= 295) || (px >= 345 && px <= 615)));
            drive_pixel(px, py);
            drive_pixel($urandom_range(344, 296), $urandom_range(1023, 0));
        end
        finish_test("outside and gap", base);

        base = errors;
        for (int i = 0; i < PIPE_PIXELS; i++) begin
            drive_pixel($urandom_range(639, 0), $urandom_range(479, 0));
            pc_cells     <= random_cells();
            player_cells <= random_cells();
        end
        finish_test("pipelining", base);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: battleship_video.f
+incdir+verif
logic/board_color_pkg.sv
logic/board_geometry_pkg.sv
logic/row_decoder.sv
logic/board_painter.sv
logic/board_compositor.sv
logic/battleship_video.sv
verif/battleship_video_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --assert --timing
TOP       := battleship_video_tb
FILELIST  := battleship_video.f
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
